/* logic/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // general register number
    typedef logic [4:0] reg_addr_t;

    typedef logic [13:0] csr_num_t;

    typedef logic [5:0] ecode_t;

    // instruction classes seen by writeback, loads count as alu
    typedef enum logic [2:0] {
        op_alu,
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_ertn,
        op_syscall,
        op_break,
        op_rdcntid
    } wb_op_t;

    // csr numbers
    localparam csr_num_t csr_crmd   = 14'h0;
    localparam csr_num_t csr_prmd   = 14'h1;
    localparam csr_num_t csr_estat  = 14'h5;
    localparam csr_num_t csr_era    = 14'h6;
    localparam csr_num_t csr_badv   = 14'h7;
    localparam csr_num_t csr_eentry = 14'hc;
    localparam csr_num_t csr_save0  = 14'h30;
    localparam csr_num_t csr_tid    = 14'h40;

    // exception codes
    localparam ecode_t ecode_adef = 6'h8;
    localparam ecode_t ecode_ale  = 6'h9;
    localparam ecode_t ecode_sys  = 6'hb;
    localparam ecode_t ecode_brk  = 6'hc;
    localparam ecode_t ecode_ine  = 6'hd;

endpackage

`default_nettype wire

/* logic/wb_csr_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface wb_csr_if;

    // access side
    wb_pkg::csr_num_t csr_rd_num;
    wb_pkg::word_t    csr_rvalue;
    logic             csr_we;
    wb_pkg::word_t    csr_wmask;
    wb_pkg::word_t    csr_wvalue;

    // exception and return commit
    logic             ex_commit;
    wb_pkg::ecode_t   ex_ecode;
    wb_pkg::word_t    ex_pc;
    wb_pkg::word_t    ex_vaddr;
    logic             ex_badv_we;
    logic             ertn_commit;

    // redirect targets
    wb_pkg::word_t    eentry;
    wb_pkg::word_t    era;

    modport decode (
        output csr_rd_num, csr_we, csr_wmask, csr_wvalue,
        output ex_commit, ex_ecode, ex_pc, ex_vaddr, ex_badv_we, ertn_commit
    );

    modport csr (
        input  csr_rd_num, csr_we, csr_wmask, csr_wvalue,
        input  ex_commit, ex_ecode, ex_pc, ex_vaddr, ex_badv_we, ertn_commit,
        output csr_rvalue, eentry, era
    );

endinterface

`default_nettype wire

/* logic/wb_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              ms_valid,
    output logic              allowin,
    input  wb_pkg::wb_op_t    ms_op,
    input  wb_pkg::word_t     ms_pc,
    input  logic              ms_gr_we,
    input  wb_pkg::reg_addr_t ms_dest,
    input  wb_pkg::word_t     ms_result,
    input  wb_pkg::word_t     ms_rj,
    input  wb_pkg::word_t     ms_rkd,
    input  wb_pkg::csr_num_t  ms_csr_num,
    input  logic              ms_adef,
    input  logic              ms_ine,
    input  logic              ms_ale,
    input  wb_pkg::word_t     ms_bad_addr,
    wb_csr_if.decode          csr,
    output logic              ws_valid,
    output logic              rf_req,
    output logic              use_csr,
    output wb_pkg::reg_addr_t rf_dest,
    output wb_pkg::word_t     alu_result,
    output logic              ex_commit,
    output logic              ertn_commit
);

    logic              valid_q;
    wb_pkg::wb_op_t    op_q;
    wb_pkg::word_t     pc_q;
    logic              gr_we_q;
    wb_pkg::reg_addr_t dest_q;
    wb_pkg::word_t     result_q;
    wb_pkg::word_t     rj_q;
    wb_pkg::word_t     rkd_q;
    wb_pkg::csr_num_t  csr_num_q;
    logic              adef_q;
    logic              ine_q;
    logic              ale_q;
    wb_pkg::word_t     bad_addr_q;
    logic              raise;
    wb_pkg::ecode_t    ecode;
    logic              badv_we;
    wb_pkg::word_t     vaddr;

    // stage is never stalled from below
    assign allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (ex_commit || ertn_commit) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && allowin) begin
            op_q       <= ms_op;
            pc_q       <= ms_pc;
            gr_we_q    <= ms_gr_we;
            dest_q     <= ms_dest;
            result_q   <= ms_result;
            rj_q       <= ms_rj;
            rkd_q      <= ms_rkd;
            csr_num_q  <= ms_csr_num;
            adef_q     <= ms_adef;
            ine_q      <= ms_ine;
            ale_q      <= ms_ale;
            bad_addr_q <= ms_bad_addr;
        end
    end

    // fixed exception priority
    always_comb begin
        raise   = 1'b1;
        ecode   = '0;
        badv_we = 1'b0;
        vaddr   = '0;
        if (op_q == wb_pkg::op_syscall) begin
            ecode = wb_pkg::ecode_sys;
        end else if (op_q == wb_pkg::op_break) begin
            ecode = wb_pkg::ecode_brk;
        end else if (adef_q) begin
            ecode   = wb_pkg::ecode_adef;
            badv_we = 1'b1;
            vaddr   = pc_q;
        end else if (ine_q) begin
            ecode = wb_pkg::ecode_ine;
        end else if (ale_q) begin
            ecode   = wb_pkg::ecode_ale;
            badv_we = 1'b1;
            vaddr   = bad_addr_q;
        end else begin
            raise = 1'b0;
        end
    end

    assign ex_commit   = valid_q && raise;
    assign ertn_commit = valid_q && !raise && (op_q == wb_pkg::op_ertn);

    assign csr.ex_commit   = ex_commit;
    assign csr.ertn_commit = ertn_commit;
    assign csr.ex_ecode    = ecode;
    assign csr.ex_pc       = pc_q;
    assign csr.ex_vaddr    = vaddr;
    assign csr.ex_badv_we  = badv_we;

    // ertn reads era for the redirect, rdcntid reads tid
    assign csr.csr_rd_num = (op_q == wb_pkg::op_ertn)    ? wb_pkg::csr_era :
                            (op_q == wb_pkg::op_rdcntid) ? wb_pkg::csr_tid :
                            csr_num_q;

    assign csr.csr_we     = valid_q && !raise &&
                            (op_q == wb_pkg::op_csrwr || op_q == wb_pkg::op_csrxchg);
    assign csr.csr_wmask  = (op_q == wb_pkg::op_csrxchg) ? rj_q : '1;
    assign csr.csr_wvalue = rkd_q;

    assign ws_valid   = valid_q;
    assign rf_req     = gr_we_q && !raise;
    assign use_csr    = (op_q == wb_pkg::op_csrrd) || (op_q == wb_pkg::op_csrwr) ||
                        (op_q == wb_pkg::op_csrxchg) || (op_q == wb_pkg::op_rdcntid);
    assign rf_dest    = dest_q;
    assign alu_result = result_q;

endmodule

`default_nettype wire

/* logic/csr_file.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_file #(
    parameter int            num_save = 4,
    parameter wb_pkg::word_t core_id  = 32'h0
) (
    input  logic clk,
    input  logic reset,
    wb_csr_if.csr csr
);

    logic             crmd_ie;
    logic [1:0]       crmd_plv;
    logic             prmd_pie;
    logic [1:0]       prmd_pplv;
    wb_pkg::ecode_t   estat_ecode;
    wb_pkg::word_t    era_q;
    wb_pkg::word_t    badv_q;
    logic [25:0]      eentry_va;
    wb_pkg::word_t    save_q [num_save];
    wb_pkg::word_t    tid_q;

    wb_pkg::word_t    rvalue;
    wb_pkg::word_t    wr_word;
    wb_pkg::csr_num_t save_idx;
    logic             wr_crmd;
    logic             wr_prmd;
    logic             wr_era;
    logic             wr_badv;
    logic             wr_eentry;
    logic             wr_tid;

    // write and read share the number, so rvalue is the old value
    assign wr_word = (rvalue & ~csr.csr_wmask) | (csr.csr_wvalue & csr.csr_wmask);

    assign wr_crmd   = csr.csr_we && (csr.csr_rd_num == wb_pkg::csr_crmd);
    assign wr_prmd   = csr.csr_we && (csr.csr_rd_num == wb_pkg::csr_prmd);
    assign wr_era    = csr.csr_we && (csr.csr_rd_num == wb_pkg::csr_era);
    assign wr_badv   = csr.csr_we && (csr.csr_rd_num == wb_pkg::csr_badv);
    assign wr_eentry = csr.csr_we && (csr.csr_rd_num == wb_pkg::csr_eentry);
    assign wr_tid    = csr.csr_we && (csr.csr_rd_num == wb_pkg::csr_tid);

    // wraps high below save0, so out of range there too
    assign save_idx = csr.csr_rd_num - wb_pkg::csr_save0;

    // crmd, prmd and estat
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv    <= 2'b0;
            crmd_ie     <= 1'b0;
            prmd_pplv   <= 2'b0;
            prmd_pie    <= 1'b0;
            estat_ecode <= '0;
        end else if (csr.ex_commit) begin
            prmd_pplv   <= crmd_plv;
            prmd_pie    <= crmd_ie;
            crmd_plv    <= 2'b0;
            crmd_ie     <= 1'b0;
            estat_ecode <= csr.ex_ecode;
        end else if (csr.ertn_commit) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else begin
            if (wr_crmd) begin
                crmd_plv <= wr_word[1:0];
                crmd_ie  <= wr_word[2];
            end
            if (wr_prmd) begin
                prmd_pplv <= wr_word[1:0];
                prmd_pie  <= wr_word[2];
            end
        end
    end

    // address registers
    always_ff @(posedge clk) begin
        if (csr.ex_commit) begin
            era_q <= csr.ex_pc;
        end else if (wr_era) begin
            era_q <= wr_word;
        end
        if (csr.ex_commit && csr.ex_badv_we) begin
            badv_q <= csr.ex_vaddr;
        end else if (wr_badv) begin
            badv_q <= wr_word;
        end
        if (wr_eentry) begin
            eentry_va <= wr_word[31:6];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_q <= core_id;
        end else if (wr_tid) begin
            tid_q <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_save; i++) begin
                save_q[i] <= '0;
            end
        end else if (csr.csr_we) begin
            for (int i = 0; i < num_save; i++) begin
                if (save_idx == wb_pkg::csr_num_t'(i)) begin
                    save_q[i] <= wr_word;
                end
            end
        end
    end

    // read mux, unknown numbers give zero
    always_comb begin
        rvalue = '0;
        case (csr.csr_rd_num)
            wb_pkg::csr_crmd:   rvalue = {29'b0, crmd_ie, crmd_plv};
            wb_pkg::csr_prmd:   rvalue = {29'b0, prmd_pie, prmd_pplv};
            wb_pkg::csr_estat:  rvalue = {10'b0, estat_ecode, 16'b0};
            wb_pkg::csr_era:    rvalue = era_q;
            wb_pkg::csr_badv:   rvalue = badv_q;
            wb_pkg::csr_eentry: rvalue = {eentry_va, 6'b0};
            wb_pkg::csr_tid:    rvalue = tid_q;
            default: begin
                for (int i = 0; i < num_save; i++) begin
                    if (save_idx == wb_pkg::csr_num_t'(i)) begin
                        rvalue = save_q[i];
                    end
                end
            end
        endcase
    end

    assign csr.csr_rvalue = rvalue;
    assign csr.eentry     = {eentry_va, 6'b0};
    assign csr.era        = era_q;

endmodule

`default_nettype wire

/* logic/wb_result.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              ws_valid,
    input  logic              rf_req,
    input  logic              use_csr,
    input  wb_pkg::reg_addr_t rf_dest,
    input  wb_pkg::word_t     alu_result,
    input  logic              ex_commit,
    input  logic              ertn_commit,
    wb_csr_if.csr             csr,
    output logic              rf_we,
    output wb_pkg::reg_addr_t rf_waddr,
    output wb_pkg::word_t     rf_wdata,
    output logic              flush_valid,
    output wb_pkg::word_t     flush_pc
);

    // register file write
    assign rf_we    = ws_valid && rf_req;
    assign rf_waddr = rf_dest;
    assign rf_wdata = use_csr ? csr.csr_rvalue : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            flush_valid <= 1'b0;
        end else begin
            flush_valid <= ex_commit || ertn_commit;
        end
    end

    // era sampled before the ertn edge updates anything
    always_ff @(posedge clk) begin
        if (ex_commit) begin
            flush_pc <= csr.eentry;
        end else if (ertn_commit) begin
            flush_pc <= csr.era;
        end
    end

endmodule

`default_nettype wire

/* logic/wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage #(
    parameter int            num_save = 4,
    parameter wb_pkg::word_t core_id  = 32'h0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ms_valid,
    output logic              allowin,
    input  wb_pkg::wb_op_t    ms_op,
    input  wb_pkg::word_t     ms_pc,
    input  logic              ms_gr_we,
    input  wb_pkg::reg_addr_t ms_dest,
    input  wb_pkg::word_t     ms_result,
    input  wb_pkg::word_t     ms_rj,
    input  wb_pkg::word_t     ms_rkd,
    input  wb_pkg::csr_num_t  ms_csr_num,
    input  logic              ms_adef,
    input  logic              ms_ine,
    input  logic              ms_ale,
    input  wb_pkg::word_t     ms_bad_addr,
    output logic              rf_we,
    output wb_pkg::reg_addr_t rf_waddr,
    output wb_pkg::word_t     rf_wdata,
    output logic              flush_valid,
    output wb_pkg::word_t     flush_pc,
    output wb_pkg::word_t     debug_pc
);

    logic              ws_valid;
    logic              rf_req;
    logic              use_csr;
    wb_pkg::reg_addr_t rf_dest;
    wb_pkg::word_t     alu_result;
    logic              ex_commit;
    logic              ertn_commit;

    wb_csr_if csr_bus ();

    wb_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .ms_valid    (ms_valid),
        .allowin     (allowin),
        .ms_op       (ms_op),
        .ms_pc       (ms_pc),
        .ms_gr_we    (ms_gr_we),
        .ms_dest     (ms_dest),
        .ms_result   (ms_result),
        .ms_rj       (ms_rj),
        .ms_rkd      (ms_rkd),
        .ms_csr_num  (ms_csr_num),
        .ms_adef     (ms_adef),
        .ms_ine      (ms_ine),
        .ms_ale      (ms_ale),
        .ms_bad_addr (ms_bad_addr),
        .csr         (csr_bus.decode),
        .ws_valid    (ws_valid),
        .rf_req      (rf_req),
        .use_csr     (use_csr),
        .rf_dest     (rf_dest),
        .alu_result  (alu_result),
        .ex_commit   (ex_commit),
        .ertn_commit (ertn_commit)
    );

    csr_file #(
        .num_save (num_save),
        .core_id  (core_id)
    ) u_csr_file (
        .clk   (clk),
        .reset (reset),
        .csr   (csr_bus.csr)
    );

    wb_result u_result (
        .clk         (clk),
        .reset       (reset),
        .ws_valid    (ws_valid),
        .rf_req      (rf_req),
        .use_csr     (use_csr),
        .rf_dest     (rf_dest),
        .alu_result  (alu_result),
        .ex_commit   (ex_commit),
        .ertn_commit (ertn_commit),
        .csr         (csr_bus.csr),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .flush_valid (flush_valid),
        .flush_pc    (flush_pc)
    );

    // pc of the instruction held in the stage
    assign debug_pc = csr_bus.ex_pc;

endmodule

`default_nettype wire

/* dv/tb_wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_stage;

    typedef struct {
        string             name;
        wb_pkg::wb_op_t    op;
        wb_pkg::word_t     pc;
        wb_pkg::csr_num_t  csr_num;
        wb_pkg::word_t     rj;
        wb_pkg::word_t     rkd;
        wb_pkg::word_t     result;
        logic              gr_we;
        wb_pkg::reg_addr_t dest;
        logic [2:0]        exc;
        wb_pkg::word_t     bad_addr;
        logic              squash;
        logic              exp_we;
        wb_pkg::word_t     exp_wdata;
        logic              exp_flush;
        wb_pkg::word_t     exp_flush_pc;
    } row_t;

    logic              clk;
    logic              reset;
    logic              ms_valid;
    logic              allowin;
    wb_pkg::wb_op_t    ms_op;
    wb_pkg::word_t     ms_pc;
    logic              ms_gr_we;
    wb_pkg::reg_addr_t ms_dest;
    wb_pkg::word_t     ms_result;
    wb_pkg::word_t     ms_rj;
    wb_pkg::word_t     ms_rkd;
    wb_pkg::csr_num_t  ms_csr_num;
    logic              ms_adef;
    logic              ms_ine;
    logic              ms_ale;
    wb_pkg::word_t     ms_bad_addr;
    logic              rf_we;
    wb_pkg::reg_addr_t rf_waddr;
    wb_pkg::word_t     rf_wdata;
    logic              flush_valid;
    wb_pkg::word_t     flush_pc;
    wb_pkg::word_t     debug_pc;

    row_t rows[$];
    int   errors = 0;
    int   passed = 0;
    int   cycles = 0;
    int   limit  = 40;
    int   cur_test = 0;

    wb_stage #(
        .num_save (4),
        .core_id  (32'h5)
    ) u_wb_stage (
        .clk         (clk),
        .reset       (reset),
        .ms_valid    (ms_valid),
        .allowin     (allowin),
        .ms_op       (ms_op),
        .ms_pc       (ms_pc),
        .ms_gr_we    (ms_gr_we),
        .ms_dest     (ms_dest),
        .ms_result   (ms_result),
        .ms_rj       (ms_rj),
        .ms_rkd      (ms_rkd),
        .ms_csr_num  (ms_csr_num),
        .ms_adef     (ms_adef),
        .ms_ine      (ms_ine),
        .ms_ale      (ms_ale),
        .ms_bad_addr (ms_bad_addr),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .flush_valid (flush_valid),
        .flush_pc    (flush_pc),
        .debug_pc    (debug_pc)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the tests did not finish within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic add_row(input string name, input wb_pkg::wb_op_t op, input wb_pkg::word_t pc,
                           input wb_pkg::csr_num_t csr_num, input wb_pkg::word_t rj,
                           input wb_pkg::word_t rkd, input wb_pkg::word_t result,
                           input logic gr_we, input wb_pkg::reg_addr_t dest,
                           input logic [2:0] exc, input wb_pkg::word_t bad_addr,
                           input logic squash, input logic exp_we,
                           input wb_pkg::word_t exp_wdata, input logic exp_flush,
                           input wb_pkg::word_t exp_flush_pc);
        row_t r;
        r.name = name;
        r.op = op;
        r.pc = pc;
        r.csr_num = csr_num;
        r.rj = rj;
        r.rkd = rkd;
        r.result = result;
        r.gr_we = gr_we;
        r.dest = dest;
        r.exc = exc;
        r.bad_addr = bad_addr;
        r.squash = squash;
        r.exp_we = exp_we;
        r.exp_wdata = exp_wdata;
        r.exp_flush = exp_flush;
        r.exp_flush_pc = exp_flush_pc;
        rows.push_back(r);
    endtask

    task automatic check_value(input string sig, input wb_pkg::word_t got,
                               input wb_pkg::word_t exp);
        assert (got === exp) else begin
            $display("error: %s got 0x%h, expected 0x%h in test %0d", sig, got, exp, cur_test);
            errors++;
        end
    endtask

    task automatic drive_row(input row_t r);
        ms_valid    = 1'b1;
        ms_op       = r.op;
        ms_pc       = r.pc;
        ms_gr_we    = r.gr_we;
        ms_dest     = r.dest;
        ms_result   = r.result;
        ms_rj       = r.rj;
        ms_rkd      = r.rkd;
        ms_csr_num  = r.csr_num;
        ms_adef     = r.exc[2];
        ms_ine      = r.exc[1];
        ms_ale      = r.exc[0];
        ms_bad_addr = r.bad_addr;
    endtask

    // alu write that should be dropped by the flush
    task automatic offer_squashed();
        ms_valid    = 1'b1;
        ms_op       = wb_pkg::op_alu;
        ms_gr_we    = 1'b1;
        ms_dest     = 5'd20;
        ms_result   = 32'hdead_beef;
        ms_adef     = 1'b0;
        ms_ine      = 1'b0;
        ms_ale      = 1'b0;
    endtask

    task automatic build_rows();
        // name, op, pc, csr, rj, rkd, result, gr_we, dest, adef/ine/ale, bad addr, squash,
        // then expected rf_we, rf_wdata, flush_valid, flush_pc
        add_row("alu write", wb_pkg::op_alu, 32'h1c00_0000, wb_pkg::csr_crmd, '0, '0,
                32'h1234_5678, 1'b1, 5'd4, 3'b000, '0, 1'b0, 1'b1, 32'h1234_5678, 1'b0, '0);
        add_row("csrwr save0", wb_pkg::op_csrwr, 32'h1c00_0004, wb_pkg::csr_save0, '0,
                32'ha5a5_0f0f, '0, 1'b1, 5'd5, 3'b000, '0, 1'b0, 1'b1, '0, 1'b0, '0);
        add_row("csrrd save0", wb_pkg::op_csrrd, 32'h1c00_0008, wb_pkg::csr_save0, '0, '0,
                '0, 1'b1, 5'd6, 3'b000, '0, 1'b0, 1'b1, 32'ha5a5_0f0f, 1'b0, '0);
        add_row("csrxchg save0", wb_pkg::op_csrxchg, 32'h1c00_000c, wb_pkg::csr_save0,
                32'h0000_ffff, 32'h1234_5678, '0, 1'b1, 5'd7, 3'b000, '0, 1'b0, 1'b1,
                32'ha5a5_0f0f, 1'b0, '0);
        add_row("csrrd save0", wb_pkg::op_csrrd, 32'h1c00_0010, wb_pkg::csr_save0, '0, '0,
                '0, 1'b1, 5'd8, 3'b000, '0, 1'b0, 1'b1, 32'ha5a5_5678, 1'b0, '0);
        add_row("rdcntid", wb_pkg::op_rdcntid, 32'h1c00_0014, wb_pkg::csr_crmd, '0, '0,
                '0, 1'b1, 5'd9, 3'b000, '0, 1'b0, 1'b1, 32'h5, 1'b0, '0);
        add_row("csrwr eentry", wb_pkg::op_csrwr, 32'h1c00_0018, wb_pkg::csr_eentry, '0,
                32'h1c00_8a7f, '0, 1'b0, 5'd0, 3'b000, '0, 1'b0, 1'b0, '0, 1'b0, '0);
        add_row("csrwr crmd", wb_pkg::op_csrwr, 32'h1c00_001c, wb_pkg::csr_crmd, '0,
                32'h7, '0, 1'b1, 5'd10, 3'b000, '0, 1'b0, 1'b1, '0, 1'b0, '0);
        add_row("syscall", wb_pkg::op_syscall, 32'h1c00_0100, wb_pkg::csr_crmd, '0, '0,
                '0, 1'b1, 5'd11, 3'b000, '0, 1'b1, 1'b0, '0, 1'b1, 32'h1c00_8a40);
        add_row("csrrd era", wb_pkg::op_csrrd, 32'h1c00_8a40, wb_pkg::csr_era, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h1c00_0100, 1'b0, '0);
        add_row("csrrd estat", wb_pkg::op_csrrd, 32'h1c00_8a44, wb_pkg::csr_estat, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h000b_0000, 1'b0, '0);
        add_row("csrrd crmd", wb_pkg::op_csrrd, 32'h1c00_8a48, wb_pkg::csr_crmd, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, '0, 1'b0, '0);
        add_row("csrrd prmd", wb_pkg::op_csrrd, 32'h1c00_8a4c, wb_pkg::csr_prmd, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h7, 1'b0, '0);
        add_row("ale", wb_pkg::op_alu, 32'h1c00_0200, wb_pkg::csr_crmd, '0, '0,
                32'h55, 1'b1, 5'd13, 3'b001, 32'h0000_1003, 1'b0, 1'b0, '0, 1'b1,
                32'h1c00_8a40);
        add_row("csrrd badv", wb_pkg::op_csrrd, 32'h1c00_8a40, wb_pkg::csr_badv, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h0000_1003, 1'b0, '0);
        add_row("csrrd estat", wb_pkg::op_csrrd, 32'h1c00_8a44, wb_pkg::csr_estat, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h0009_0000, 1'b0, '0);
        add_row("adef and ale", wb_pkg::op_alu, 32'h1c00_0302, wb_pkg::csr_crmd, '0, '0,
                32'h66, 1'b1, 5'd13, 3'b101, 32'h0000_2007, 1'b0, 1'b0, '0, 1'b1,
                32'h1c00_8a40);
        add_row("csrrd estat", wb_pkg::op_csrrd, 32'h1c00_8a44, wb_pkg::csr_estat, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h0008_0000, 1'b0, '0);
        add_row("csrrd badv", wb_pkg::op_csrrd, 32'h1c00_8a48, wb_pkg::csr_badv, '0, '0,
                '0, 1'b1, 5'd12, 3'b000, '0, 1'b0, 1'b1, 32'h1c00_0302, 1'b0, '0);
        add_row("csrwr prmd", wb_pkg::op_csrwr, 32'h1c00_8a4c, wb_pkg::csr_prmd, '0,
                32'h5, '0, 1'b1, 5'd14, 3'b000, '0, 1'b0, 1'b1, '0, 1'b0, '0);
        add_row("csrwr era", wb_pkg::op_csrwr, 32'h1c00_8a50, wb_pkg::csr_era, '0,
                32'h1c00_0400, '0, 1'b1, 5'd15, 3'b000, '0, 1'b0, 1'b1, 32'h1c00_0302,
                1'b0, '0);
        add_row("ertn", wb_pkg::op_ertn, 32'h1c00_8a54, wb_pkg::csr_crmd, '0, '0,
                '0, 1'b0, 5'd0, 3'b000, '0, 1'b0, 1'b0, '0, 1'b1, 32'h1c00_0400);
        add_row("csrrd crmd", wb_pkg::op_csrrd, 32'h1c00_0400, wb_pkg::csr_crmd, '0, '0,
                '0, 1'b1, 5'd16, 3'b000, '0, 1'b0, 1'b1, 32'h5, 1'b0, '0);
    endtask

    initial begin
        int errs_before;
        row_t r;
        reset       = 1'b1;
        ms_valid    = 1'b0;
        ms_op       = wb_pkg::op_alu;
        ms_pc       = '0;
        ms_gr_we    = 1'b0;
        ms_dest     = '0;
        ms_result   = '0;
        ms_rj       = '0;
        ms_rkd      = '0;
        ms_csr_num  = '0;
        ms_adef     = 1'b0;
        ms_ine      = 1'b0;
        ms_ale      = 1'b0;
        ms_bad_addr = '0;
        build_rows();
        limit = rows.size() * 4 + 40;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            cur_test = i;
            errs_before = errors;
            @(negedge clk);
            while (!allowin) @(negedge clk);
            drive_row(r);

            // instruction now in the stage
            @(negedge clk);
            check_value("allowin", {31'b0, allowin}, 32'h1);
            check_value("flush_valid", {31'b0, flush_valid}, 32'h0);
            check_value("debug_pc", debug_pc, r.pc);
            check_value("rf_we", {31'b0, rf_we}, {31'b0, r.exp_we});
            if (r.exp_we) begin
                check_value("rf_waddr", {27'b0, rf_waddr}, {27'b0, r.dest});
                check_value("rf_wdata", rf_wdata, r.exp_wdata);
            end
            if (r.squash) begin
                offer_squashed();
            end else begin
                ms_valid = 1'b0;
            end

            @(negedge clk);
            ms_valid = 1'b0;
            check_value("rf_we", {31'b0, rf_we}, 32'h0);
            check_value("flush_valid", {31'b0, flush_valid}, {31'b0, r.exp_flush});
            if (r.exp_flush) begin
                check_value("flush_pc", flush_pc, r.exp_flush_pc);
                // flush lasts one cycle only
                @(negedge clk);
                check_value("flush_valid", {31'b0, flush_valid}, 32'h0);
                check_value("rf_we", {31'b0, rf_we}, 32'h0);
            end

            if (errors == errs_before) begin
                passed++;
                $display("test %0d %s: ok", i, r.name);
            end else begin
                $display("test %0d %s: mismatch", i, r.name);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 rows.size(), passed, rows.size() - passed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wb_stage.f */
logic/wb_pkg.sv
logic/wb_csr_if.sv
logic/wb_decode.sv
logic/csr_file.sv
logic/wb_result.sv
logic/wb_stage.sv
dv/tb_wb_stage.sv

/* run.sh */
#!/bin/sh
# build and run the writeback stage testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f wb_stage.f --top-module tb_wb_stage -o tb_wb_stage
./obj_dir/tb_wb_stage > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi
